// ==== design/audio_pkg.sv ====
package audio_pkg;

  // Audio sample format
  localparam int SAMPLE_BITS = 8;

  // I2S bit clock, hwclk cycles per half period
  localparam int I2S_HALF_PERIOD = 24;
  localparam int DIV_BITS = $clog2(I2S_HALF_PERIOD);
  localparam logic [DIV_BITS-1:0] DIV_LAST = DIV_BITS'(I2S_HALF_PERIOD - 1);

  // Echo ring in external SRAM
  localparam int ECHO_DELAY = 64;                   // In samples
  localparam int RING_WORDS = 32;                   // 32-bit words, four samples each
  localparam int RING_IDX_BITS = $clog2(RING_WORDS) + 2;
  localparam logic [RING_IDX_BITS-1:0] ECHO_OFFSET = RING_IDX_BITS'(ECHO_DELAY);
  localparam logic [31:0] RING_BASE = 32'h0000_1000;

  // Sample buffer FSM encodings
  localparam logic [2:0] SB_IDLE    = 3'd0;
  localparam logic [2:0] SB_WR_REQ  = 3'd1;
  localparam logic [2:0] SB_WR_WAIT = 3'd2;
  localparam logic [2:0] SB_RD_REQ  = 3'd3;
  localparam logic [2:0] SB_RD_WAIT = 3'd4;

  // One SRAM word, seen as a bus word or as four byte-lane samples
  typedef union packed {
    logic [31:0] word;
    logic [3:0][SAMPLE_BITS-1:0] lane;             // Lane = sample index mod 4
  } sram_word_t;

endpackage

// ==== design/clk_divider.sv ====
module clk_divider (
  input  logic hwclk,
  input  logic arst_n,
  output logic bit_clk,
  output logic rise,
  output logic fall
);

  logic [audio_pkg::DIV_BITS-1:0] cnt;   // Half-period counter

  // Strobes line up with the bit_clk change itself
  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      cnt     <= '0;
      bit_clk <= 1'b0;
      rise    <= 1'b0;
      fall    <= 1'b0;
    end else begin
      rise <= 1'b0;                      // Single-cycle pulses
      fall <= 1'b0;
      if (cnt == audio_pkg::DIV_LAST) begin
        cnt     <= '0;
        bit_clk <= ~bit_clk;
        rise    <= ~bit_clk;             // Low going high
        fall    <= bit_clk;              // High going low
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// ==== design/adc_to_i2s.sv ====
module adc_to_i2s (
  input  logic                             hwclk,
  input  logic                             arst_n,
  input  logic                             adc_serial_in,
  input  logic                             rise,
  output logic [audio_pkg::SAMPLE_BITS-1:0] sample_in,
  output logic                             sample_valid,
  output logic                             ws
);

  logic [audio_pkg::SAMPLE_BITS-1:0] shreg;                 // Incoming bits, MSB first
  logic [$clog2(audio_pkg::SAMPLE_BITS)-1:0] bit_cnt;       // Bits taken this frame
  logic [audio_pkg::SAMPLE_BITS-1:0] next_word;

  // Word as it stands after the current bit
  assign next_word = {shreg[audio_pkg::SAMPLE_BITS-2:0], adc_serial_in};

  // Frame control
  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt      <= '0;
      sample_valid <= 1'b0;
      ws           <= 1'b0;
    end else begin
      sample_valid <= 1'b0;
      if (rise) begin
        bit_cnt <= bit_cnt + 1'b1;     // Wraps after the last bit
        if (&bit_cnt) begin            // Eighth bit arriving now
          sample_valid <= 1'b1;
          ws           <= ~ws;         // New frame on the ADC side
        end
      end
    end
  end

  // Data path
  always_ff @(posedge hwclk) begin
    if (rise) begin
      shreg <= next_word;
      if (&bit_cnt) begin
        sample_in <= next_word;        // Full sample out with the strobe
      end
    end
  end

endmodule

// ==== design/sample_buffer.sv ====
module sample_buffer (
  input  logic                             hwclk,
  input  logic                             arst_n,
  input  logic [audio_pkg::SAMPLE_BITS-1:0] sample_in,
  input  logic                             sample_valid,
  input  logic                             busy,
  input  logic [31:0]                      rdata,
  output logic                             req,
  output logic                             wr,
  output logic [31:0]                      adr,
  output logic [31:0]                      dat_w,
  output logic [3:0]                       sel,
  output logic [audio_pkg::SAMPLE_BITS-1:0] delayed_sample,
  output logic                             delayed_valid
);

  logic [2:0] state;
  logic [audio_pkg::RING_IDX_BITS-1:0] wr_idx;    // Ring slot for the next sample
  logic [audio_pkg::RING_IDX_BITS-1:0] rd_idx;    // Slot written ECHO_DELAY samples ago
  logic accept;
  audio_pkg::sram_word_t wr_word;
  audio_pkg::sram_word_t rd_word;

  // Byte address of the word that holds a given slot
  function automatic logic [31:0] word_addr(input logic [audio_pkg::RING_IDX_BITS-1:0] idx);
    logic [31:0] offs;
    offs = 32'({idx[audio_pkg::RING_IDX_BITS-1:2], 2'b00});
    return audio_pkg::RING_BASE + offs;
  endfunction

  assign rd_idx = wr_idx - audio_pkg::ECHO_OFFSET;   // Wraps mod 128
  assign accept = (state == audio_pkg::SB_IDLE) && sample_valid && !busy;

  always_comb begin
    wr_word.word = '0;
    wr_word.lane[wr_idx[1:0]] = sample_in;           // Only the addressed lane
    rd_word.word = rdata;
  end

  // Write then read, one bus request each
  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      state         <= audio_pkg::SB_IDLE;
      wr_idx        <= '0;
      req           <= 1'b0;
      delayed_valid <= 1'b0;
    end else begin
      req           <= 1'b0;
      delayed_valid <= 1'b0;
      case (state)
        audio_pkg::SB_IDLE: if (accept) begin      // Busy samples never get here
          req   <= 1'b1;
          state <= audio_pkg::SB_WR_REQ;
        end
        audio_pkg::SB_WR_REQ: state <= audio_pkg::SB_WR_WAIT;   // busy rises next
        audio_pkg::SB_WR_WAIT: if (!busy) begin
          req   <= 1'b1;                           // Read of the delayed slot
          state <= audio_pkg::SB_RD_REQ;
        end
        audio_pkg::SB_RD_REQ: state <= audio_pkg::SB_RD_WAIT;
        audio_pkg::SB_RD_WAIT: if (!busy) begin
          delayed_valid <= 1'b1;
          wr_idx        <= wr_idx + 1'b1;          // One step per accepted sample
          state         <= audio_pkg::SB_IDLE;
        end
        default: state <= audio_pkg::SB_IDLE;
      endcase
    end
  end

  // Request fields and the picked byte
  always_ff @(posedge hwclk) begin
    if (accept) begin
      wr    <= 1'b1;
      adr   <= word_addr(wr_idx);
      dat_w <= wr_word.word;
      sel   <= 4'b0001 << wr_idx[1:0];             // One-hot byte lane
    end
    if (state == audio_pkg::SB_WR_WAIT && !busy) begin
      wr  <= 1'b0;
      adr <= word_addr(rd_idx);
      sel <= 4'b1111;                              // Whole word, lane picked after
    end
    if (state == audio_pkg::SB_RD_WAIT && !busy) begin
      delayed_sample <= rd_word.lane[rd_idx[1:0]];
    end
  end

endmodule

// ==== design/wishbone_manager.sv ====
module wishbone_manager (
  input  logic        hwclk,
  input  logic        arst_n,
  input  logic        req,
  input  logic        wr,
  input  logic [31:0] adr,
  input  logic [31:0] dat_w,
  input  logic [3:0]  sel,
  output logic        busy,
  output logic [31:0] rdata,
  input  logic [31:0] wdati,
  input  logic        wack,
  output logic [31:0] wadr,
  output logic [31:0] wdato,
  output logic [3:0]  wsel,
  output logic        wwe,
  output logic        wstb,
  output logic        wcyc
);

  logic active;   // Cycle in progress on the bus

  // Single classic cycle, strobe and cycle move together
  assign wcyc = active;
  assign wstb = active;
  assign busy = active;

  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      active <= 1'b0;
      wwe    <= 1'b0;
    end else if (!active) begin
      if (req) begin
        active <= 1'b1;          // Bus raised the cycle after req
        wwe    <= wr;
      end
    end else if (wack) begin
      active <= 1'b0;            // Drop on the ack edge
      wwe    <= 1'b0;
    end
  end

  // Address and data held steady for the whole cycle
  always_ff @(posedge hwclk) begin
    if (!active && req) begin
      wadr  <= adr;
      wdato <= dat_w;
      wsel  <= sel;
    end
    if (active && wack && !wwe) begin
      rdata <= wdati;            // Read data on the ack edge
    end
  end

endmodule

// ==== design/echo_effect.sv ====
module echo_effect (
  input  logic                             hwclk,
  input  logic                             arst_n,
  input  logic                             echo_en,
  input  logic [audio_pkg::SAMPLE_BITS-1:0] sample_in,
  input  logic                             sample_valid,
  input  logic [audio_pkg::SAMPLE_BITS-1:0] delayed_sample,
  input  logic                             delayed_valid,
  output logic [audio_pkg::SAMPLE_BITS-1:0] mix_sample,
  output logic                             mix_valid
);

  logic [audio_pkg::SAMPLE_BITS-1:0] cur;     // Sample waiting on its delayed copy
  logic [audio_pkg::SAMPLE_BITS-1:0] held;    // Sample the buffer dropped
  logic [audio_pkg::SAMPLE_BITS-1:0] mixed;
  logic wait_del;
  logic held_v;
  logic finish;
  logic dropped;

  // Half of each, cannot overflow 8 bits
  assign mixed = (cur >> 1) + (delayed_sample >> 1);

  assign finish  = wait_del && delayed_valid;
  assign dropped = sample_valid && wait_del && !delayed_valid;   // Buffer still busy

  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      wait_del  <= 1'b0;
      held_v    <= 1'b0;
      mix_valid <= 1'b0;
    end else begin
      mix_valid <= 1'b0;
      if (finish) begin
        mix_valid <= 1'b1;           // One cycle after delayed_valid
        wait_del  <= 1'b0;
      end else if (held_v && !wait_del) begin
        mix_valid <= 1'b1;           // Pass-through of a dropped frame
        held_v    <= 1'b0;
      end
      if (dropped) begin
        held_v <= 1'b1;
      end else if (sample_valid) begin
        wait_del <= 1'b1;            // Buffer took this one
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (finish) begin
      mix_sample <= echo_en ? mixed : cur;
    end else if (held_v && !wait_del) begin
      mix_sample <= held;            // No echo for it
    end
    if (dropped) begin
      held <= sample_in;
    end else if (sample_valid) begin
      cur <= sample_in;
    end
  end

endmodule

// ==== design/i2s_to_dac.sv ====
module i2s_to_dac (
  input  logic                             hwclk,
  input  logic                             arst_n,
  input  logic                             fall,
  input  logic [audio_pkg::SAMPLE_BITS-1:0] mix_sample,
  input  logic                             mix_valid,
  input  logic [1:0]                       volume,
  output logic                             dac_out,
  output logic                             dac_ws
);

  logic [audio_pkg::SAMPLE_BITS-1:0] hold;                  // Attenuated, waiting for a frame
  logic [audio_pkg::SAMPLE_BITS-1:0] shreg;                 // Bits still to send
  logic [$clog2(audio_pkg::SAMPLE_BITS)-1:0] bits_left;
  logic hold_v;
  logic start;

  // New frame only once the last one is fully out
  assign start = fall && hold_v && (bits_left == '0);

  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      hold_v    <= 1'b0;
      bits_left <= '0;
      dac_out   <= 1'b0;
      dac_ws    <= 1'b0;
    end else begin
      if (mix_valid) begin
        hold_v <= 1'b1;
      end else if (start) begin
        hold_v <= 1'b0;
      end
      if (start) begin
        dac_ws    <= ~dac_ws;                            // Frame boundary
        dac_out   <= hold[audio_pkg::SAMPLE_BITS-1];    // MSB goes first
        bits_left <= '1;
      end else if (fall) begin
        if (bits_left != '0) begin
          dac_out   <= shreg[audio_pkg::SAMPLE_BITS-1];
          bits_left <= bits_left - 1'b1;
        end else begin
          dac_out <= 1'b0;                               // Idle line
        end
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (mix_valid) begin
      hold <= mix_sample >> volume;                      // 0 to 3 steps quieter
    end
    if (start) begin
      shreg <= hold << 1;
    end else if (fall) begin
      shreg <= shreg << 1;
    end
  end

endmodule

// ==== design/audio_top.sv ====
module audio_top (
  input  logic        hwclk,
  input  logic        arst_n,
  input  logic        adc_serial_in,
  input  logic        echo_en,
  input  logic [1:0]  volume,
  input  logic [31:0] wdati,
  input  logic        wack,
  output logic        wsADC,
  output logic        i2sclk,
  output logic        i2sclk_out,
  output logic        dac_out,
  output logic        dac_ws,
  output logic [31:0] wadr,
  output logic [31:0] wdato,
  output logic [3:0]  wsel,
  output logic        wwe,
  output logic        wstb,
  output logic        wcyc
);

  logic adc_rise;
  logic dac_fall;
  logic [audio_pkg::SAMPLE_BITS-1:0] sample_in;
  logic sample_valid;
  logic req;
  logic wr;
  logic [31:0] adr;
  logic [31:0] dat_w;
  logic [3:0] sel;
  logic busy;
  logic [31:0] rdata;
  logic [audio_pkg::SAMPLE_BITS-1:0] delayed_sample;
  logic delayed_valid;
  logic [audio_pkg::SAMPLE_BITS-1:0] mix_sample;
  logic mix_valid;

  // Capture side bit clock
  clk_divider div_i2sclk (.hwclk(hwclk), .arst_n(arst_n),
    .bit_clk(i2sclk), .rise(adc_rise), .fall());

  // Playback side bit clock
  clk_divider div_i2sclk_out (.hwclk(hwclk), .arst_n(arst_n),
    .bit_clk(i2sclk_out), .rise(), .fall(dac_fall));

  adc_to_i2s adc (.hwclk(hwclk), .arst_n(arst_n), .adc_serial_in(adc_serial_in),
    .rise(adc_rise),
    .sample_in(sample_in), .sample_valid(sample_valid), .ws(wsADC));   // To buffer and echo

  sample_buffer ring (.hwclk(hwclk), .arst_n(arst_n),
    .sample_in(sample_in), .sample_valid(sample_valid),                // From ADC
    .busy(busy), .rdata(rdata),                                        // From manager
    .req(req), .wr(wr), .adr(adr), .dat_w(dat_w), .sel(sel),           // To manager
    .delayed_sample(delayed_sample), .delayed_valid(delayed_valid));   // To echo

  wishbone_manager wb_mgr (.hwclk(hwclk), .arst_n(arst_n),
    .req(req), .wr(wr), .adr(adr), .dat_w(dat_w), .sel(sel),
    .busy(busy), .rdata(rdata),
    .wdati(wdati), .wack(wack),                                        // SRAM side
    .wadr(wadr), .wdato(wdato), .wsel(wsel), .wwe(wwe), .wstb(wstb), .wcyc(wcyc));

  echo_effect echo (.hwclk(hwclk), .arst_n(arst_n), .echo_en(echo_en),
    .sample_in(sample_in), .sample_valid(sample_valid),
    .delayed_sample(delayed_sample), .delayed_valid(delayed_valid),
    .mix_sample(mix_sample), .mix_valid(mix_valid));                   // To DAC

  i2s_to_dac dac (.hwclk(hwclk), .arst_n(arst_n), .fall(dac_fall),
    .mix_sample(mix_sample), .mix_valid(mix_valid), .volume(volume),
    .dac_out(dac_out), .dac_ws(dac_ws));

endmodule

// ==== test/tb_sram_model.sv ====
module tb_sram_model (
  input  logic        hwclk,
  input  logic        arst_n,
  input  logic [2:0]  ack_delay,   // Wait cycles before ack, 1 to 6
  input  logic [31:0] wadr,
  input  logic [31:0] wdato,
  input  logic [3:0]  wsel,
  input  logic        wwe,
  input  logic        wstb,
  input  logic        wcyc,
  output logic [31:0] wdati,
  output logic        wack
);

  logic [31:0] mem [0:1023];       // Word addressed by wadr[11:2]
  logic [2:0]  cnt;
  logic [9:0]  idx;

  // Responder updates just after the clock edge
  always @(posedge hwclk) begin
    #1;
    idx = wadr[11:2];
    if (!arst_n) begin
      wack  = 1'b0;
      wdati = '0;
      cnt   = '0;
      for (int i = 0; i < 1024; i++) begin
        mem[i] = '0;               // Ring starts silent
      end
    end else if (wack) begin
      wack = 1'b0;                 // One ack per cycle
      cnt  = '0;
    end else if (wcyc && wstb) begin
      if (cnt + 3'd1 >= ack_delay) begin
        wack = 1'b1;
        if (wwe) begin
          for (int b = 0; b < 4; b++) begin
            if (wsel[b]) mem[idx][8*b +: 8] = wdato[8*b +: 8];   // Byte lanes
          end
        end else begin
          wdati = mem[idx];
        end
      end else begin
        cnt = cnt + 3'd1;
      end
    end
  end

endmodule

// ==== test/tb_audio_top.sv ====
module tb_audio_top;

  localparam int NUM_FRAMES    = 100;                            // Past ECHO_DELAY
  localparam int FRAME_CYCLES  = 16 * audio_pkg::I2S_HALF_PERIOD;
  localparam int FRAME_TIMEOUT = 3 * FRAME_CYCLES;
  localparam logic [31:0] RING_END = audio_pkg::RING_BASE + 32'(4 * audio_pkg::RING_WORDS);

  logic hwclk = 1'b0;
  logic arst_n = 1'b0;
  logic adc_serial_in = 1'b0;
  logic echo_en = 1'b0;
  logic [1:0] volume = 2'd0;
  logic [2:0] ack_delay = 3'd1;
  logic [31:0] wdati;
  logic wack;
  logic wsADC, i2sclk, i2sclk_out, dac_out, dac_ws;
  logic [31:0] wadr;
  logic [31:0] wdato;
  logic [3:0] wsel;
  logic wwe, wstb, wcyc;

  logic [31:0] seed = 32'h5112;
  logic [7:0] cur_sample = '0;
  logic [7:0] shadow [0:127];                                    // Mirror of the ring
  logic [7:0] exp_q [$];
  logic [7:0] dly, mix, shift_dac;
  logic clk_in_q = 1'b0, clk_out_q = 1'b0, ws_adc_q = 1'b0, ws_dac_q = 1'b0;
  logic first_done = 1'b0;
  logic timed_out = 1'b0;
  int bit_idx = 0, sent = 0, nbits = 0;
  int adc_gap = 0, dac_gap = 0, adc_frames = 0, dac_starts = 0, dac_frames = 0;
  int proto_errs = 0, data_errs = 0, wait_cnt = 0, last = 0;

  audio_top UUT (.hwclk(hwclk), .arst_n(arst_n), .adc_serial_in(adc_serial_in),
    .echo_en(echo_en), .volume(volume), .wdati(wdati), .wack(wack), .wsADC(wsADC),
    .i2sclk(i2sclk), .i2sclk_out(i2sclk_out), .dac_out(dac_out), .dac_ws(dac_ws),
    .wadr(wadr), .wdato(wdato), .wsel(wsel), .wwe(wwe), .wstb(wstb), .wcyc(wcyc));

  tb_sram_model sram (.hwclk(hwclk), .arst_n(arst_n), .ack_delay(ack_delay),
    .wadr(wadr), .wdato(wdato), .wsel(wsel), .wwe(wwe), .wstb(wstb), .wcyc(wcyc),
    .wdati(wdati), .wack(wack));

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    forever #4 hwclk = ~hwclk;
  end

  // Quiet outputs until the first frame is in
  assert property (@(posedge hwclk) disable iff (!arst_n)
    !first_done |-> !(wcyc || wstb || wwe || dac_out || dac_ws || wsADC))
    else begin
      proto_errs++;
      $display("Output active before the first frame");
    end
  assert property (@(posedge hwclk) disable iff (!arst_n) wstb |-> wcyc)
    else begin
      proto_errs++;
      $display("Wishbone strobe raised without cycle");
    end
  assert property (@(posedge hwclk) disable iff (!arst_n) (wstb && !wack) |=>
    ($stable(wadr) && $stable(wdato) && $stable(wsel) && $stable(wwe)))
    else begin
      proto_errs++;
      $display("Wishbone request changed before ack");
    end
  // Write lane follows the index of the sample just sent
  assert property (@(posedge hwclk) disable iff (!arst_n)
    (wstb && wwe) |-> (wsel == (4'b0001 << 2'(sent - 1))))
    else begin
      proto_errs++;
      $display("ERROR wsel got 0x%h expected 0x%h", $sampled(wsel),
        4'b0001 << 2'($sampled(sent) - 1));
    end
  assert property (@(posedge hwclk) disable iff (!arst_n)
    wstb |-> (wadr >= audio_pkg::RING_BASE && wadr < RING_END))
    else begin
      proto_errs++;
      $display("ERROR wadr got 0x%h outside ring", $sampled(wadr));
    end

  // Stimulus and DAC decode, just after each edge
  always @(posedge hwclk) begin
    #1;
    if (!arst_n) begin
      for (int i = 0; i < 128; i++) shadow[i] = '0;
    end else begin
      if (i2sclk && !clk_in_q) begin                             // ADC bit slot
        if (bit_idx == 0) begin
          seed = lcg_step(seed);
          cur_sample = seed[23:16];
          seed = lcg_step(seed);
          echo_en = seed[20];
          volume = seed[25:24];
          ack_delay = 3'd1 + (seed[12:10] % 3'd6);
        end
        adc_serial_in = cur_sample[7 - bit_idx];                 // MSB first
        if (bit_idx == 7) begin
          dly = shadow[7'(sent - audio_pkg::ECHO_DELAY)];
          mix = echo_en ? (cur_sample >> 1) + (dly >> 1) : cur_sample;
          exp_q.push_back(mix >> volume);
          shadow[7'(sent)] = cur_sample;
          sent++;
          first_done = 1'b1;
        end
        bit_idx = (bit_idx + 1) % 8;
      end
      clk_in_q = i2sclk;
      adc_gap++;
      dac_gap++;
      if (wsADC != ws_adc_q) begin
        if (adc_frames > 0) assert (adc_gap == FRAME_CYCLES) else begin
          data_errs++;
          $display("ERROR wsADC period got 0x%h expected 0x%h", adc_gap, FRAME_CYCLES);
        end
        adc_frames++;
        adc_gap = 0;
      end
      ws_adc_q = wsADC;
      if (!i2sclk_out && clk_out_q) begin                        // DAC bit slot
        if (dac_ws != ws_dac_q) begin
          if (dac_starts > 0) assert (dac_gap == FRAME_CYCLES) else begin
            data_errs++;
            $display("ERROR dac_ws period got 0x%h expected 0x%h", dac_gap, FRAME_CYCLES);
          end
          dac_starts++;
          dac_gap = 0;
          shift_dac = {7'd0, dac_out};
          nbits = 1;
          ws_dac_q = dac_ws;
        end else if (nbits > 0) begin
          shift_dac = {shift_dac[6:0], dac_out};
          nbits++;
        end
        if (nbits == 8) begin
          nbits = 0;
          if (exp_q.size() == 0) begin
            data_errs++;
            $display("DAC frame arrived with no ADC sample to match");
          end else begin
            mix = exp_q.pop_front();
            assert (shift_dac == mix) else begin
              data_errs++;
              $display("ERROR dac_out frame %0d got 0x%h expected 0x%h", dac_frames,
                shift_dac, mix);
            end
          end
          dac_frames++;
        end
      end
      clk_out_q = i2sclk_out;
    end
  end

  initial begin
    repeat (16) @(posedge hwclk);
    #1 arst_n = 1'b1;
    while (dac_frames < NUM_FRAMES && !timed_out) begin
      last = dac_frames;
      wait_cnt = 0;
      while (dac_frames == last && wait_cnt < FRAME_TIMEOUT) begin
        @(posedge hwclk);
        wait_cnt++;
      end
      if (dac_frames == last) begin
        timed_out = 1'b1;
        $display("Timed out waiting for DAC frame %0d", last);
      end
    end
    assert (adc_frames - dac_frames >= 0 && adc_frames - dac_frames <= 2) else begin
      data_errs++;
      $display("ADC frames %0d and DAC frames %0d do not line up", adc_frames, dac_frames);
    end
    $display("Errors: protocol %0d, data %0d", proto_errs, data_errs);
    if (timed_out || proto_errs != 0 || data_errs != 0) begin
      $display("Result: FAILED");
    end else begin
      $display("Result: PASSED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
design/audio_pkg.sv
design/clk_divider.sv
design/adc_to_i2s.sv
design/sample_buffer.sv
design/wishbone_manager.sv
design/echo_effect.sv
design/i2s_to_dac.sv
design/audio_top.sv
test/tb_sram_model.sv
test/tb_audio_top.sv

// ==== Makefile ====
# Verilator build and run for the audio echo testbench

VERILATOR ?= verilator
TOP       ?= tb_audio_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard design/*.sv) $(wildcard test/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG)
	cat $(LOG)
	grep -q "^Result: PASSED" $(LOG)

check:
	grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
